//--- common/pipe_cfg.svh
// pipeline back end configuration
// data width, destination register address width,
// data memory depth and control-stage reset pc

`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

`define PIPE_DATA_W      32
`define PIPE_RF_ADR_W    5
`define PIPE_DMEM_WORDS  16
`define PIPE_RESET_PC    32'h100

`endif

//--- common/pipe_pkg.sv
// shared pipeline types
// opcode enum, exception code enum and
// an opcode helper used by the execute and control stages

package pipe_pkg;

   // instruction opcodes, codes 10 to 15 are illegal
   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_ADD   = 4'd1,
      OP_SUB   = 4'd2,
      OP_AND   = 4'd3,
      OP_OR    = 4'd4,
      OP_XOR   = 4'd5,
      OP_JAL   = 4'd6,
      OP_JR    = 4'd7,
      OP_LOAD  = 4'd8,
      OP_STORE = 4'd9
   } opcode_e;

   // exception code reported with each retired instruction
   typedef enum logic [2:0] {
      EXC_NONE       = 3'd0,
      EXC_ILLEGAL    = 3'd1,
      EXC_JUMP_ALIGN = 3'd2,
      EXC_DATA_ALIGN = 3'd3
   } exc_e;

   // true for opcodes that access the data memory
   function automatic logic is_mem_op(input opcode_e op);
      logic mem;
      mem = (op == OP_LOAD) || (op == OP_STORE);
      return mem;
   endfunction

endpackage

//--- common/exec_ctrl_if.sv
// execute to control stage bundle
// exec modport drives, ctrl modport samples

`timescale 1ns/1ns

`include "pipe_cfg.svh"

interface exec_ctrl_if;

   pipe_pkg::opcode_e           opcode;
   logic [`PIPE_DATA_W-1:0]     alu_result;
   // a+b, used as memory address
   logic [`PIPE_DATA_W-1:0]     adder_result;
   logic [`PIPE_DATA_W-1:0]     store_data;
   logic [`PIPE_RF_ADR_W-1:0]   rd_adr;
   logic                        rf_wb;
   logic [`PIPE_DATA_W-1:0]     pc;
   pipe_pkg::exc_e              exc;

   modport exec (
      output opcode, alu_result, adder_result, store_data,
      output rd_adr, rf_wb, pc, exc
   );

   modport ctrl (
      input opcode, alu_result, adder_result, store_data,
      input rd_adr, rf_wb, pc, exc
   );

endinterface

//--- rtl/execute_stage.sv
// execute stage
// alu, address adder and jal link value,
// illegal opcode, jump alignment and data alignment checks

`timescale 1ns/1ns

`include "pipe_cfg.svh"

module execute_stage (
   input  pipe_pkg::opcode_e           opcode_i,
   input  logic [`PIPE_DATA_W-1:0]     op_a_i,
   input  logic [`PIPE_DATA_W-1:0]     op_b_i,
   input  logic [`PIPE_RF_ADR_W-1:0]   rd_adr_i,
   input  logic [`PIPE_DATA_W-1:0]     pc_i,
   exec_ctrl_if.exec                   ex
);

   localparam logic [`PIPE_DATA_W-1:0] LINK_OFS = 4;

   logic [`PIPE_DATA_W-1:0] sum;
   logic [`PIPE_DATA_W-1:0] alu_res;
   logic                    wb_req;
   pipe_pkg::exc_e          exc;

   assign sum = op_a_i + op_b_i;

   always_comb begin
      alu_res = '0;
      wb_req  = 1'b0;
      exc     = pipe_pkg::EXC_NONE;
      case (opcode_i)
         pipe_pkg::OP_NOP: begin
            alu_res = '0;
         end
         pipe_pkg::OP_ADD: begin
            alu_res = sum;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_SUB: begin
            alu_res = op_a_i - op_b_i;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_AND: begin
            alu_res = op_a_i & op_b_i;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_OR: begin
            alu_res = op_a_i | op_b_i;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_XOR: begin
            alu_res = op_a_i ^ op_b_i;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_JAL: begin
            // link value goes to rd
            alu_res = pc_i + LINK_OFS;
            wb_req  = 1'b1;
         end
         pipe_pkg::OP_JR: begin
            // jump target from register b, must be word aligned
            alu_res = op_b_i;
            if (|op_b_i[1:0]) begin
               exc = pipe_pkg::EXC_JUMP_ALIGN;
            end
         end
         pipe_pkg::OP_LOAD: begin
            wb_req = 1'b1;
         end
         pipe_pkg::OP_STORE: begin
            wb_req = 1'b0;
         end
         default: begin
            exc = pipe_pkg::EXC_ILLEGAL;
         end
      endcase
      // word accesses only
      if (pipe_pkg::is_mem_op(opcode_i) && (|sum[1:0])) begin
         exc = pipe_pkg::EXC_DATA_ALIGN;
      end
   end

   assign ex.opcode       = opcode_i;
   assign ex.alu_result   = alu_res;
   assign ex.adder_result = sum;
   assign ex.store_data   = op_b_i;
   assign ex.rd_adr       = rd_adr_i;
   assign ex.pc           = pc_i;
   assign ex.exc          = exc;
   // an excepting instruction never writes the register file
   assign ex.rf_wb        = wb_req & (exc == pipe_pkg::EXC_NONE);

endmodule

//--- execute_ctrl/execute_ctrl_reg.sv
// execute to control pipeline register
// advance, flush and load stall control,
// memory request to the control-stage lsu,
// writeback register with write enable hold-off

`timescale 1ns/1ns

`include "pipe_cfg.svh"

module execute_ctrl_reg (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        insn_valid_i,
   input  logic                        flush_i,
   exec_ctrl_if.ctrl                   ex,
   input  logic                        lsu_valid_i,
   input  logic [`PIPE_DATA_W-1:0]     lsu_rdata_i,
   output pipe_pkg::opcode_e           ctrl_op_o,
   output logic [`PIPE_DATA_W-1:0]     ctrl_adr_o,
   output logic [`PIPE_DATA_W-1:0]     ctrl_wdata_o,
   output logic                        lsu_start_o,
   output logic                        busy_o,
   output logic                        wb_valid_o,
   output logic                        wb_we_o,
   output logic [`PIPE_RF_ADR_W-1:0]   wb_rd_o,
   output logic [`PIPE_DATA_W-1:0]     wb_data_o,
   output logic [`PIPE_DATA_W-1:0]     wb_pc_o,
   output pipe_pkg::exc_e              wb_exc_o
);

   logic                        padv;
   logic                        ex_bubble;
   logic                        ex_mem_ok;
   logic                        ctrl_done;

   logic                        ctrl_valid_q;
   logic                        ctrl_fresh_q;
   logic                        ctrl_load_q;
   logic                        ctrl_store_q;
   logic                        ctrl_rf_wb_q;
   logic [`PIPE_RF_ADR_W-1:0]   ctrl_rd_q;
   logic [`PIPE_DATA_W-1:0]     ctrl_pc_q;
   pipe_pkg::exc_e              ctrl_exc_q;

   assign padv      = insn_valid_i & ~busy_o;
   assign ex_bubble = (ex.opcode == pipe_pkg::OP_NOP);
   // misaligned accesses never reach the lsu
   assign ex_mem_ok = (ex.exc != pipe_pkg::EXC_DATA_ALIGN);

   // loads wait for lsu data, everything else completes at once
   assign ctrl_done = ctrl_valid_q & (~ctrl_load_q | lsu_valid_i);
   assign busy_o    = ctrl_valid_q & ctrl_load_q & ~lsu_valid_i;

   // advance has priority over flush so a new instruction is kept
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_op_o    <= pipe_pkg::OP_NOP;
         ctrl_valid_q <= 1'b0;
         ctrl_load_q  <= 1'b0;
         ctrl_store_q <= 1'b0;
      end else if (padv) begin
         ctrl_op_o    <= ex.opcode;
         ctrl_valid_q <= ~ex_bubble;
         ctrl_load_q  <= (ex.opcode == pipe_pkg::OP_LOAD) & ex_mem_ok;
         ctrl_store_q <= (ex.opcode == pipe_pkg::OP_STORE) & ex_mem_ok;
      end else if (flush_i) begin
         ctrl_op_o    <= pipe_pkg::OP_NOP;
         ctrl_valid_q <= 1'b0;
         ctrl_load_q  <= 1'b0;
         ctrl_store_q <= 1'b0;
      end else if (ctrl_done) begin
         ctrl_valid_q <= 1'b0;
      end
   end

   // first cycle in the control stage, used for the lsu strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_fresh_q <= 1'b0;
      end else begin
         ctrl_fresh_q <= padv & ~ex_bubble;
      end
   end

   assign lsu_start_o = ctrl_fresh_q & (ctrl_load_q | ctrl_store_q) & ~flush_i;

   // pc holds across nop bubbles
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl_pc_q <= `PIPE_RESET_PC;
      end else if (padv & ~ex_bubble) begin
         ctrl_pc_q <= ex.pc;
      end
   end

   always_ff @(posedge clk) begin
      if (padv) begin
         ctrl_adr_o   <= pipe_pkg::is_mem_op(ex.opcode) ? ex.adder_result : ex.alu_result;
         ctrl_wdata_o <= ex.store_data;
         ctrl_rd_q    <= ex.rd_adr;
         ctrl_rf_wb_q <= ex.rf_wb;
         ctrl_exc_q   <= ex.exc;
      end
   end

   // writeback, a flush kills the completing control-stage instruction
   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid_o <= 1'b0;
         wb_we_o    <= 1'b0;
      end else begin
         wb_valid_o <= ctrl_done & ~flush_i;
         wb_we_o    <= ctrl_done & ~flush_i & ctrl_rf_wb_q;
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_done) begin
         wb_rd_o   <= ctrl_rd_q;
         wb_data_o <= ctrl_load_q ? lsu_rdata_i : ctrl_adr_o;
         wb_pc_o   <= ctrl_pc_q;
         wb_exc_o  <= ctrl_exc_q;
      end
   end

endmodule

//--- rtl/ctrl_lsu.sv
// control-stage load/store unit
// word-addressed data memory cleared at reset,
// stores complete at once, loads return data one cycle later

`timescale 1ns/1ns

`include "pipe_cfg.svh"

module ctrl_lsu (
   input  logic                       clk,
   input  logic                       rst,
   input  pipe_pkg::opcode_e          op_i,
   input  logic [`PIPE_DATA_W-1:0]    adr_i,
   input  logic [`PIPE_DATA_W-1:0]    wdata_i,
   input  logic                       start_i,
   output logic                       valid_o,
   output logic [`PIPE_DATA_W-1:0]    rdata_o
);

   localparam int IDX_W = $clog2(`PIPE_DMEM_WORDS);

   logic [`PIPE_DATA_W-1:0] mem [`PIPE_DMEM_WORDS];
   logic [IDX_W-1:0]        idx;
   logic                    is_load;
   logic                    load_q;
   logic [`PIPE_DATA_W-1:0] rdata_q;

   // word index from address bits above the byte offset
   assign idx     = adr_i[IDX_W+1:2];
   assign is_load = (op_i == pipe_pkg::OP_LOAD);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PIPE_DMEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (start_i && (op_i == pipe_pkg::OP_STORE)) begin
         mem[idx] <= wdata_i;
      end
   end

   // load read is registered
   always_ff @(posedge clk) begin
      if (rst) begin
         load_q <= 1'b0;
      end else begin
         load_q <= start_i & is_load;
      end
   end

   always_ff @(posedge clk) begin
      if (start_i && is_load) begin
         rdata_q <= mem[idx];
      end
   end

   assign valid_o = (start_i & ~is_load) | load_q;
   assign rdata_o = rdata_q;

endmodule

//--- rtl/pipe_tail_top.sv
// pipeline back end top level
// execute stage, execute/ctrl register with writeback,
// control-stage lsu and the bundle between execute and ctrl

`timescale 1ns/1ns

`include "pipe_cfg.svh"

module pipe_tail_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        insn_valid_i,
   input  pipe_pkg::opcode_e           opcode_i,
   input  logic [`PIPE_DATA_W-1:0]     op_a_i,
   input  logic [`PIPE_DATA_W-1:0]     op_b_i,
   input  logic [`PIPE_RF_ADR_W-1:0]   rd_adr_i,
   input  logic [`PIPE_DATA_W-1:0]     pc_i,
   input  logic                        flush_i,
   output logic                        busy_o,
   output logic                        wb_valid_o,
   output logic                        wb_we_o,
   output logic [`PIPE_RF_ADR_W-1:0]   wb_rd_o,
   output logic [`PIPE_DATA_W-1:0]     wb_data_o,
   output logic [`PIPE_DATA_W-1:0]     wb_pc_o,
   output pipe_pkg::exc_e              wb_exc_o
);

   pipe_pkg::opcode_e        ctrl_op;
   logic [`PIPE_DATA_W-1:0]  ctrl_adr;
   logic [`PIPE_DATA_W-1:0]  ctrl_wdata;
   logic                     ctrl_lsu_start;
   logic                     lsu_valid;
   logic [`PIPE_DATA_W-1:0]  lsu_rdata;

   exec_ctrl_if i_exec_ctrl_if ();

   execute_stage i_execute_stage (
      .opcode_i (opcode_i),
      .op_a_i   (op_a_i),
      .op_b_i   (op_b_i),
      .rd_adr_i (rd_adr_i),
      .pc_i     (pc_i),
      .ex       (i_exec_ctrl_if.exec)
   );

   execute_ctrl_reg i_execute_ctrl_reg (
      .clk          (clk),
      .rst          (rst),
      .insn_valid_i (insn_valid_i),
      .flush_i      (flush_i),
      .ex           (i_exec_ctrl_if.ctrl),
      .lsu_valid_i  (lsu_valid),
      .lsu_rdata_i  (lsu_rdata),
      .ctrl_op_o    (ctrl_op),
      .ctrl_adr_o   (ctrl_adr),
      .ctrl_wdata_o (ctrl_wdata),
      .lsu_start_o  (ctrl_lsu_start),
      .busy_o       (busy_o),
      .wb_valid_o   (wb_valid_o),
      .wb_we_o      (wb_we_o),
      .wb_rd_o      (wb_rd_o),
      .wb_data_o    (wb_data_o),
      .wb_pc_o      (wb_pc_o),
      .wb_exc_o     (wb_exc_o)
   );

   ctrl_lsu i_ctrl_lsu (
      .clk     (clk),
      .rst     (rst),
      .op_i    (ctrl_op),
      .adr_i   (ctrl_adr),
      .wdata_i (ctrl_wdata),
      .start_i (ctrl_lsu_start),
      .valid_o (lsu_valid),
      .rdata_o (lsu_rdata)
   );

endmodule

//--- sim/tb_pipe_tail.sv
// testbench for the pipeline back end
// stimulus table with expected values from a reference model,
// retire queue, compare tasks and a cycle limit

`timescale 1ns/1ns

`include "pipe_cfg.svh"

module tb_pipe_tail;

   localparam int N_ROWS        = 20;
   localparam int CYC_LIMIT     = 20 * N_ROWS + 50;
   localparam int FL_NONE       = 0;
   localparam int FL_WITH_ISSUE = 1;
   localparam int FL_AFTER      = 2;

   logic                        clk;
   logic                        rst;
   logic                        insn_valid_i;
   pipe_pkg::opcode_e           opcode_i;
   logic [`PIPE_DATA_W-1:0]     op_a_i;
   logic [`PIPE_DATA_W-1:0]     op_b_i;
   logic [`PIPE_RF_ADR_W-1:0]   rd_adr_i;
   logic [`PIPE_DATA_W-1:0]     pc_i;
   logic                        flush_i;
   logic                        busy_o;
   logic                        wb_valid_o;
   logic                        wb_we_o;
   logic [`PIPE_RF_ADR_W-1:0]   wb_rd_o;
   logic [`PIPE_DATA_W-1:0]     wb_data_o;
   logic [`PIPE_DATA_W-1:0]     wb_pc_o;
   pipe_pkg::exc_e              wb_exc_o;

   // stimulus table and expected values
   string                       row_name   [N_ROWS];
   pipe_pkg::opcode_e           row_op     [N_ROWS];
   logic [`PIPE_DATA_W-1:0]     row_a      [N_ROWS];
   logic [`PIPE_DATA_W-1:0]     row_b      [N_ROWS];
   logic [`PIPE_RF_ADR_W-1:0]   row_rd     [N_ROWS];
   logic [`PIPE_DATA_W-1:0]     row_pc     [N_ROWS];
   int                          row_flush  [N_ROWS];
   logic                        exp_retire [N_ROWS];
   logic                        exp_we     [N_ROWS];
   logic [`PIPE_DATA_W-1:0]     exp_data   [N_ROWS];
   pipe_pkg::exc_e              exp_exc    [N_ROWS];
   int                          exp_lat    [N_ROWS];
   int                          issue_edge [N_ROWS];

   int                          n_rows = 0;
   int                          pend_q [$];
   int                          cyc = 0;
   int                          busy_cnt = 0;
   int                          exp_busy = 0;
   int                          ret_row;
   logic [31:0]                 rng;

   pipe_tail_top i_pipe_tail_top (
      .clk          (clk),
      .rst          (rst),
      .insn_valid_i (insn_valid_i),
      .opcode_i     (opcode_i),
      .op_a_i       (op_a_i),
      .op_b_i       (op_b_i),
      .rd_adr_i     (rd_adr_i),
      .pc_i         (pc_i),
      .flush_i      (flush_i),
      .busy_o       (busy_o),
      .wb_valid_o   (wb_valid_o),
      .wb_we_o      (wb_we_o),
      .wb_rd_o      (wb_rd_o),
      .wb_data_o    (wb_data_o),
      .wb_pc_o      (wb_pc_o),
      .wb_exc_o     (wb_exc_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift_next();
      logic [31:0] x;
      x   = rng;
      x   = x ^ (x << 13);
      x   = x ^ (x >> 17);
      x   = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped at cycle %0d", cyc);
   endtask

   task automatic check_data(input string name, input logic [`PIPE_DATA_W-1:0] exp,
                             input logic [`PIPE_DATA_W-1:0] act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_exc(input string name, input pipe_pkg::exc_e exp,
                            input pipe_pkg::exc_e act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s: expected %s (%0d), actual %0d",
                                  name, exp.name(), exp, act));
      end
   endtask

   task automatic check_rd(input string name, input logic [`PIPE_RF_ADR_W-1:0] exp,
                           input logic [`PIPE_RF_ADR_W-1:0] act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   task automatic add_row(input string nm, input pipe_pkg::opcode_e op,
                          input logic [`PIPE_DATA_W-1:0] a, input logic [`PIPE_DATA_W-1:0] b,
                          input logic [`PIPE_RF_ADR_W-1:0] rd,
                          input logic [`PIPE_DATA_W-1:0] pc, input int fl);
      row_name[n_rows]  = nm;
      row_op[n_rows]    = op;
      row_a[n_rows]     = a;
      row_b[n_rows]     = b;
      row_rd[n_rows]    = rd;
      row_pc[n_rows]    = pc;
      row_flush[n_rows] = fl;
      n_rows++;
   endtask

   task automatic build_table();
      // alu rows go back to back
      add_row("add_rand", pipe_pkg::OP_ADD, xorshift_next(), xorshift_next(), 5'd1, 32'h104, FL_NONE);
      add_row("sub_rand", pipe_pkg::OP_SUB, xorshift_next(), xorshift_next(), 5'd2, 32'h108, FL_NONE);
      add_row("and_rand", pipe_pkg::OP_AND, xorshift_next(), xorshift_next(), 5'd3, 32'h10c, FL_NONE);
      add_row("or_rand", pipe_pkg::OP_OR, xorshift_next(), xorshift_next(), 5'd4, 32'h110, FL_NONE);
      add_row("xor_rand", pipe_pkg::OP_XOR, xorshift_next(), xorshift_next(), 5'd5, 32'h114, FL_NONE);
      add_row("jal_link", pipe_pkg::OP_JAL, 32'h0, 32'h0, 5'd9, 32'h200, FL_NONE);
      add_row("jr_aligned", pipe_pkg::OP_JR, 32'h0, 32'h300, 5'd0, 32'h204, FL_NONE);
      add_row("jr_misaligned", pipe_pkg::OP_JR, 32'h0, 32'h302, 5'd0, 32'h208, FL_NONE);
      add_row("store_w2", pipe_pkg::OP_STORE, 32'h8, 32'hcafe0000, 5'd0, 32'h20c, FL_NONE);
      add_row("load_w2", pipe_pkg::OP_LOAD, 32'h8, 32'h0, 5'd7, 32'h210, FL_NONE);
      add_row("store_misaligned", pipe_pkg::OP_STORE, 32'h9, 32'h12340000, 5'd0, 32'h214,
              FL_NONE);
      add_row("load_misaligned", pipe_pkg::OP_LOAD, 32'h6, 32'h0, 5'd8, 32'h218, FL_NONE);
      add_row("load_w2_again", pipe_pkg::OP_LOAD, 32'h8, 32'h0, 5'd10, 32'h21c, FL_NONE);
      add_row("illegal_op", pipe_pkg::opcode_e'(4'd12), 32'h1, 32'h2, 5'd11, 32'h220, FL_NONE);
      add_row("flush_after", pipe_pkg::OP_ADD, xorshift_next(), xorshift_next(), 5'd12,
              32'h224, FL_AFTER);
      add_row("flush_with_issue", pipe_pkg::OP_ADD, xorshift_next(), xorshift_next(), 5'd13,
              32'h228, FL_WITH_ISSUE);
      add_row("nop_bubble", pipe_pkg::OP_NOP, 32'h0, 32'h0, 5'd0, 32'h22c, FL_NONE);
      add_row("load_w0_reset", pipe_pkg::OP_LOAD, 32'h0, 32'h0, 5'd14, 32'h230, FL_NONE);
      add_row("add_after_load", pipe_pkg::OP_ADD, xorshift_next(), xorshift_next(), 5'd15,
              32'h234, FL_NONE);
      add_row("xor_last", pipe_pkg::OP_XOR, xorshift_next(), xorshift_next(), 5'd16,
              32'h238, FL_NONE);
   endtask

   // reference model in issue order, memory starts cleared
   task automatic compute_expected();
      logic [`PIPE_DATA_W-1:0] mem [`PIPE_DMEM_WORDS];
      logic [`PIPE_DATA_W-1:0] adr;
      logic                    wr;
      logic                    killed;
      for (int i = 0; i < `PIPE_DMEM_WORDS; i++) begin
         mem[i] = '0;
      end
      for (int r = 0; r < n_rows; r++) begin
         adr         = row_a[r] + row_b[r];
         killed      = (row_flush[r] == FL_AFTER);
         wr          = 1'b0;
         exp_data[r] = '0;
         exp_exc[r]  = pipe_pkg::EXC_NONE;
         case (row_op[r])
            pipe_pkg::OP_NOP: begin
               wr = 1'b0;
            end
            pipe_pkg::OP_ADD: begin
               exp_data[r] = row_a[r] + row_b[r];
               wr          = 1'b1;
            end
            pipe_pkg::OP_SUB: begin
               exp_data[r] = row_a[r] - row_b[r];
               wr          = 1'b1;
            end
            pipe_pkg::OP_AND: begin
               exp_data[r] = row_a[r] & row_b[r];
               wr          = 1'b1;
            end
            pipe_pkg::OP_OR: begin
               exp_data[r] = row_a[r] | row_b[r];
               wr          = 1'b1;
            end
            pipe_pkg::OP_XOR: begin
               exp_data[r] = row_a[r] ^ row_b[r];
               wr          = 1'b1;
            end
            pipe_pkg::OP_JAL: begin
               exp_data[r] = row_pc[r] + 32'd4;
               wr          = 1'b1;
            end
            pipe_pkg::OP_JR: begin
               if (row_b[r][1:0] != 2'b00) begin
                  exp_exc[r] = pipe_pkg::EXC_JUMP_ALIGN;
               end
            end
            pipe_pkg::OP_LOAD: begin
               wr = 1'b1;
               if (adr[1:0] != 2'b00) begin
                  exp_exc[r] = pipe_pkg::EXC_DATA_ALIGN;
               end else begin
                  exp_data[r] = mem[adr[5:2]];
               end
            end
            pipe_pkg::OP_STORE: begin
               if (adr[1:0] != 2'b00) begin
                  exp_exc[r] = pipe_pkg::EXC_DATA_ALIGN;
               end else if (!killed) begin
                  mem[adr[5:2]] = row_b[r];
               end
            end
            default: begin
               exp_exc[r] = pipe_pkg::EXC_ILLEGAL;
            end
         endcase
         exp_we[r]     = wr && (exp_exc[r] == pipe_pkg::EXC_NONE);
         exp_retire[r] = (row_op[r] != pipe_pkg::OP_NOP) && !killed;
         // an aligned load spends one extra cycle in the control stage
         if ((row_op[r] == pipe_pkg::OP_LOAD) && (exp_exc[r] == pipe_pkg::EXC_NONE)) begin
            exp_lat[r] = 3;
            if (exp_retire[r]) begin
               exp_busy++;
            end
         end else begin
            exp_lat[r] = 2;
         end
      end
   endtask

   task automatic issue_row(input int r);
      if (row_flush[r] == FL_WITH_ISSUE) begin
         // drain so the flush meets an empty control stage
         insn_valid_i = 1'b0;
         repeat (3) begin
            @(posedge clk);
            #2;
         end
      end
      while (busy_o) begin
         insn_valid_i = 1'b0;
         @(posedge clk);
         #2;
      end
      opcode_i      = row_op[r];
      op_a_i        = row_a[r];
      op_b_i        = row_b[r];
      rd_adr_i      = row_rd[r];
      pc_i          = row_pc[r];
      insn_valid_i  = 1'b1;
      flush_i       = (row_flush[r] == FL_WITH_ISSUE);
      issue_edge[r] = cyc + 1;
      if (exp_retire[r]) begin
         pend_q.push_back(r);
      end
      @(posedge clk);
      #2;
      insn_valid_i = 1'b0;
      flush_i      = 1'b0;
      if (row_flush[r] == FL_AFTER) begin
         flush_i = 1'b1;
         @(posedge clk);
         #2;
         flush_i = 1'b0;
      end
   endtask

   task automatic match_retire(input int r);
      check_rd({row_name[r], " rd"}, row_rd[r], wb_rd_o);
      check_data({row_name[r], " pc"}, row_pc[r], wb_pc_o);
      check_exc({row_name[r], " exc"}, exp_exc[r], wb_exc_o);
      check_flag({row_name[r], " we"}, exp_we[r], wb_we_o);
      if (exp_we[r]) begin
         check_data({row_name[r], " data"}, exp_data[r], wb_data_o);
      end
      check_count({row_name[r], " latency"}, exp_lat[r], cyc - issue_edge[r] + 1);
   endtask

   // edge counter and run limit
   always @(posedge clk) begin
      cyc++;
      if (cyc > CYC_LIMIT) begin
         report_failure($sformatf("timeout: run exceeded %0d cycles", CYC_LIMIT));
      end
   end

   // outputs are sampled mid-cycle
   always @(negedge clk) begin
      if (!rst) begin
         if (busy_o) begin
            busy_cnt++;
         end
         if (wb_valid_o) begin
            if (pend_q.size() == 0) begin
               report_failure("wb_valid_o pulsed with no instruction expected to retire");
            end else begin
               ret_row = pend_q.pop_front();
               match_retire(ret_row);
            end
         end
      end
   end

   initial begin
      rst          = 1'b1;
      insn_valid_i = 1'b0;
      opcode_i     = pipe_pkg::OP_NOP;
      op_a_i       = '0;
      op_b_i       = '0;
      rd_adr_i     = '0;
      pc_i         = '0;
      flush_i      = 1'b0;
      rng          = 32'hcd5d;
      build_table();
      compute_expected();
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      check_flag("reset busy_o", 1'b0, busy_o);
      check_flag("reset wb_valid_o", 1'b0, wb_valid_o);
      check_flag("reset wb_we_o", 1'b0, wb_we_o);
      for (int r = 0; r < n_rows; r++) begin
         issue_row(r);
      end
      while (pend_q.size() != 0) begin
         @(posedge clk);
      end
      // catch stray retire pulses
      repeat (4) @(posedge clk);
      if (busy_cnt == exp_busy) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         report_failure($sformatf("Mismatch load busy cycles: expected %0d, actual %0d",
                                  exp_busy, busy_cnt));
      end
   end

endmodule

//--- build.f
+incdir+common
common/pipe_pkg.sv
common/exec_ctrl_if.sv
rtl/execute_stage.sv
execute_ctrl/execute_ctrl_reg.sv
rtl/ctrl_lsu.sv
rtl/pipe_tail_top.sv
sim/tb_pipe_tail.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the pipeline back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f build.f --top-module tb_pipe_tail \
   -Mdir obj_dir -o sim_tb > compile.log 2>&1
if [ $? -ne 0 ]; then
   cat compile.log
   echo "compilation failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
   exit 0
fi
exit 1
